/* program.hex */
// One instruction word per line, address rises by 4 from 0x000
// Comments give address, assembly and any store it makes
E3A00000 // 000 MOV R0,#0
E3A01005 // 004 MOV R1,#5
E2812003 // 008 ADD R2,R1,#3
E0423001 // 00C SUB R3,R2,R1
E1834002 // 010 ORR R4,R3,R2
E0045002 // 014 AND R5,R4,R2
E5802200 // 018 STR R2,[R0,#0x200] stores 8
E5803204 // 01C STR R3,[R0,#0x204] stores 3
E5804208 // 020 STR R4,[R0,#0x208] stores B
E580520C // 024 STR R5,[R0,#0x20C] stores 8
E5906204 // 028 LDR R6,[R0,#0x204]
E2867010 // 02C ADD R7,R6,#0x10
E5807210 // 030 STR R7,[R0,#0x210] stores 13
E3A08CDE // 034 MOV R8,#0xDE00
E38880AD // 038 ORR R8,R8,#0xAD poison DEAD
E3A09005 // 03C MOV R9,#5
E3A0AE22 // 040 MOV R10,#0x220
E58A9000 // 044 STR R9,[R10] stores 5,4,3,2,1 at 220..230
E28AA004 // 048 ADD R10,R10,#4
E2499001 // 04C SUB R9,R9,#1
E3590000 // 050 CMP R9,#0
4580830C // 054 STRMI R8,[R0,#0x30C] never passes
1AFFFFF9 // 058 BNE 044
EA000002 // 05C B 06C
E5808300 // 060 STR R8 poison, squashed
E5808304 // 064 STR R8 poison, squashed
E5808308 // 068 STR R8 poison, skipped
E58043FC // 06C STR R4,[R0,#0x3FC] stores B, last store
EAFFFFFE // 070 B 070

/* all.f */
armPkg.sv
memPkg.sv
datapath.sv
controller.sv
hazard.sv
memArbiter.sv
unifiedMem.sv
armSystem.sv
tb_armSystem.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f all.f --top-module tb_armSystem -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "Build or run step returned an error"
grep -q "Simulation passed" sim.log && exit 0 || exit 1

/* tb_armSystem.sv */
`timescale 1ns/10ps

module tb_armSystem
  import armPkg::*;
;

  localparam int numStores = 11;
  localparam int maxCycles = 4000;

  logic  clk;
  logic  rstN;
  word_t busAddr;
  word_t busWdata;
  logic  busWe;
  logic  busData;

  word_t expAddr [16];
  word_t expData [16];
  int    storeIdx;
  int    relCycles;
  int    errCount;
  int    waitCycles;
  int    extraDelay;
  bit    timedOut;

  armSystem u_armSystem (
    .clk(clk),
    .rstN(rstN),
    .busAddr(busAddr),
    .busWdata(busWdata),
    .busWe(busWe),
    .busData(busData)
  );

  always #50 clk = ~clk;

  // Expected stores of the test program
  initial begin
    for (int i = 0; i < 16; i++) begin
      expAddr[i] = '0;
      expData[i] = '0;
    end
    // Dependent ALU chain 5+3, 8-5, 3|8 and 11&8
    expAddr[0]  = 32'h200;
    expData[0]  = 32'h8;
    expAddr[1]  = 32'h204;
    expData[1]  = 32'h3;
    expAddr[2]  = 32'h208;
    expData[2]  = 32'hB;
    expAddr[3]  = 32'h20C;
    expData[3]  = 32'h8;
    // Load of 3 plus 0x10
    expAddr[4]  = 32'h210;
    expData[4]  = 32'h13;
    // Countdown loop
    expAddr[5]  = 32'h220;
    expData[5]  = 32'h5;
    expAddr[6]  = 32'h224;
    expData[6]  = 32'h4;
    expAddr[7]  = 32'h228;
    expData[7]  = 32'h3;
    expAddr[8]  = 32'h22C;
    expData[8]  = 32'h2;
    expAddr[9]  = 32'h230;
    expData[9]  = 32'h1;
    // Final marker store of R4
    expAddr[10] = 32'h3FC;
    expData[10] = 32'hB;
  end

  // Store pointer moves on each committed write
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      storeIdx <= 0;
    end else if (busWe) begin
      storeIdx <= storeIdx + 1;
    end
  end

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      relCycles <= 0;
    end else if (relCycles < 1000) begin
      relCycles <= relCycles + 1;
    end
  end

  // Bus is stable mid-cycle, so checks sample on the falling edge
  aStoreAddr: assert property (@(negedge clk) disable iff (!rstN)
    busWe |-> storeIdx < numStores && busAddr == expAddr[storeIdx])
    else begin
      errCount++;
      $display("ERR busAddr got %h expected %h (store %0d)", busAddr,
               (storeIdx < numStores) ? expAddr[storeIdx] : 32'hFFFFFFFF, storeIdx);
    end

  aStoreData: assert property (@(negedge clk) disable iff (!rstN)
    busWe |-> storeIdx < numStores && busWdata == expData[storeIdx])
    else begin
      errCount++;
      $display("ERR busWdata got %h expected %h (store %0d)", busWdata,
               (storeIdx < numStores) ? expData[storeIdx] : 32'hFFFFFFFF, storeIdx);
    end

  aNoPoison: assert property (@(negedge clk) disable iff (!rstN)
    busWe |-> busWdata != 32'hDEAD)
    else begin
      errCount++;
      $display("ERR busWdata got %h at busAddr %h from a squashed store", busWdata, busAddr);
    end

  aDataAddr: assert property (@(negedge clk) disable iff (!rstN)
    busData |-> busAddr >= 32'h200)
    else begin
      errCount++;
      $display("ERR busAddr got %h while data owns the bus", busAddr);
    end

  aWeOwned: assert property (@(negedge clk) disable iff (!rstN) busWe |-> busData)
    else begin
      errCount++;
      $display("A write reached the bus while fetch owned it");
    end

  aResetQuiet: assert property (@(negedge clk) !rstN |-> !busWe)
    else begin
      errCount++;
      $display("A write reached the bus during reset");
    end

  // Nothing can reach M within four cycles of release
  aEarlyWrite: assert property (@(negedge clk) disable iff (!rstN) busWe |-> relCycles >= 4)
    else begin
      errCount++;
      $display("A write reached the bus too soon after reset release");
    end

  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    errCount   = 0;
    timedOut   = 1'b0;
    waitCycles = 0;
    void'($urandom(32'hdc9a));
    extraDelay = $urandom % 8;

    repeat (16 + extraDelay) @(posedge clk);
    #1 rstN = 1'b1;

    while (storeIdx < numStores && waitCycles < maxCycles) begin
      @(posedge clk);
      waitCycles++;
    end
    if (storeIdx < numStores) begin
      timedOut = 1'b1;
      $display("Timeout: final store to 0x3fc did not arrive within %0d cycles", maxCycles);
    end

    // Extra cycles catch repeated or late stores
    waitCycles = 0;
    while (!timedOut && waitCycles < 40) begin
      @(posedge clk);
      waitCycles++;
    end
    if (storeIdx != numStores && !timedOut) begin
      errCount++;
      $display("Store count is %0d instead of %0d", storeIdx, numStores);
    end

    $display("Run ended with %0d errors, %0d stores, timeout %0d", errCount, storeIdx,
             timedOut);
    if (errCount == 0 && !timedOut) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* armSystem.sv */
`timescale 1ns/10ps

module armSystem
  import armPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  output word_t busAddr,
  output word_t busWdata,
  output logic  busWe,
  output logic  busData
);

  logic [1:0] regSrcD, immSrcD, forwardAE, forwardBE;
  logic       aluSrcE, branchTakenE, memtoRegE, memReqM, memWriteM;
  logic       regWriteM, regWriteW, memtoRegW;
  aluCtrl_t   aluCtrlE;
  flags_t     aluFlagsE;
  word_t      pcF, instrF, instrD, aluOutM, writeDataM, readDataM, memRdata;
  logic       match1EM, match1EW, match2EM, match2EW, match12DE;
  logic       stallF, stallD, flushD, flushE, fetchGrant;

  // High while the data stage holds the memory port
  assign busData = !fetchGrant;

  controller u_controller (
    .clk(clk), .rstN(rstN), .instrD(instrD), .aluFlagsE(aluFlagsE), .flushE(flushE),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .branchTakenE(branchTakenE),
    .memtoRegE(memtoRegE), .memReqM(memReqM), .memWriteM(memWriteM),
    .regWriteM(regWriteM), .regWriteW(regWriteW), .memtoRegW(memtoRegW),
    .aluCtrlE(aluCtrlE)
  );

  datapath u_datapath (
    .clk(clk), .rstN(rstN), .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE),
    .branchTakenE(branchTakenE), .aluCtrlE(aluCtrlE), .memtoRegW(memtoRegW),
    .regWriteW(regWriteW), .pcF(pcF), .instrF(instrF), .instrD(instrD),
    .aluOutM(aluOutM), .writeDataM(writeDataM), .readDataM(readDataM),
    .aluFlagsE(aluFlagsE), .match1EM(match1EM), .match1EW(match1EW),
    .match2EM(match2EM), .match2EW(match2EW), .match12DE(match12DE),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF), .stallD(stallD),
    .flushD(flushD), .flushE(flushE)
  );

  hazard u_hazard (
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM), .match2EW(match2EW),
    .match12DE(match12DE), .regWriteM(regWriteM), .regWriteW(regWriteW),
    .memtoRegE(memtoRegE), .branchTakenE(branchTakenE), .fetchGrant(fetchGrant),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF), .stallD(stallD),
    .flushD(flushD), .flushE(flushE)
  );

  memArbiter u_memArbiter (
    .clk(clk), .rstN(rstN), .pcF(pcF), .dataAddr(aluOutM), .dataWdata(writeDataM),
    .memReq(memReqM), .memWrite(memWriteM), .instrF(instrF), .readData(readDataM),
    .fetchGrant(fetchGrant), .busAddr(busAddr), .busWe(busWe), .busWdata(busWdata),
    .memRdata(memRdata)
  );

  unifiedMem u_unifiedMem (
    .clk(clk), .addr(busAddr), .we(busWe), .wdata(busWdata), .rdata(memRdata)
  );

endmodule

/* unifiedMem.sv */
`timescale 1ns/10ps

module unifiedMem
  import armPkg::*, memPkg::*;
(
  input  logic  clk,
  input  word_t addr,
  input  logic  we,
  input  word_t wdata,
  output word_t rdata
);

  word_t               mem [memDepth];
  logic [memAddrW-1:0] wordIdx;

  initial begin
    $readmemh(progFile, mem);
  end

  // Byte address to word index
  assign wordIdx = addr[memAddrW+1:2];

  assign rdata = mem[wordIdx];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wordIdx] <= wdata;
    end
  end

  aAligned: assert property (@(posedge clk) we |-> addr[1:0] == 2'b00)
    else $error("unaligned write to %h", addr);

endmodule

/* memArbiter.sv */
`timescale 1ns/10ps

module memArbiter
  import armPkg::*, memPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  word_t pcF,
  input  word_t dataAddr,
  input  word_t dataWdata,
  input  logic  memReq,
  input  logic  memWrite,
  output word_t instrF,
  output word_t readData,
  output logic  fetchGrant,
  output word_t busAddr,
  output logic  busWe,
  output word_t busWdata,
  input  word_t memRdata
);

  busOwner_t owner, lastOwner;
  word_t     selAddr;

  // Data stage has fixed priority
  assign owner      = memReq ? ownData : ownFetch;
  assign fetchGrant = (owner == ownFetch);

  assign selAddr  = (owner == ownData) ? dataAddr : pcF;
  assign busAddr  = {{(30 - memAddrW){1'b0}}, selAddr[memAddrW+1:0]};
  assign busWe    = (owner == ownData) && memWrite;
  assign busWdata = dataWdata;

  // Denied fetch hands decode a zero word
  assign instrF   = fetchGrant ? memRdata : '0;
  assign readData = (owner == ownData) ? memRdata : '0;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lastOwner <= ownFetch;
    end else begin
      lastOwner <= owner;
    end
  end

  // Without new fetches the pipeline drains within three data cycles
  aFetchResumes: assert property (@(posedge clk) disable iff (!rstN)
    (lastOwner == ownData && owner == ownData) ##1 (owner == ownData) |=>
    (owner == ownFetch))
    else $error("fetch denied for more than three cycles in a row");

endmodule

/* hazard.sv */
`timescale 1ns/10ps

module hazard (
  input  logic       match1EM,
  input  logic       match1EW,
  input  logic       match2EM,
  input  logic       match2EW,
  input  logic       match12DE,
  input  logic       regWriteM,
  input  logic       regWriteW,
  input  logic       memtoRegE,
  input  logic       branchTakenE,
  input  logic       fetchGrant,
  output logic [1:0] forwardAE,
  output logic [1:0] forwardBE,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE
);

  logic ldStall;

  // M result is newer, so it wins over W
  assign forwardAE = (match1EM && regWriteM) ? 2'b10 :
                     (match1EW && regWriteW) ? 2'b01 : 2'b00;
  assign forwardBE = (match2EM && regWriteM) ? 2'b10 :
                     (match2EW && regWriteW) ? 2'b01 : 2'b00;

  assign ldStall = match12DE && memtoRegE;

  // A taken branch still loads its target when fetch is denied
  assign stallF = ldStall || (!fetchGrant && !branchTakenE);
  assign stallD = ldStall;

  // Lost fetch leaves a bubble in D unless D is held for a load
  assign flushD = branchTakenE || (!fetchGrant && !ldStall);
  assign flushE = ldStall || branchTakenE;

endmodule

/* controller.sv */
`timescale 1ns/10ps

module controller
  import armPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  word_t      instrD,
  input  flags_t     aluFlagsE,
  input  logic       flushE,
  output logic [1:0] regSrcD,
  output logic [1:0] immSrcD,
  output logic       aluSrcE,
  output logic       branchTakenE,
  output logic       memtoRegE,
  output logic       memReqM,
  output logic       memWriteM,
  output logic       regWriteM,
  output logic       regWriteW,
  output logic       memtoRegW,
  output aluCtrl_t   aluCtrlE
);

  instrClass_t classD;
  aluCtrl_t    aluCtrlD;
  logic        validD, dpOkD, aluSrcD, regWriteD, memWriteD, memtoRegD, memReqD, branchD;
  logic [1:0]  flagWriteD;

  logic        validE, regWriteE, memWriteE, memtoRegRawE, memReqE, branchE, passE;
  logic [1:0]  flagWriteE;
  cond_t       condE;
  flags_t      flagReg;
  logic        memtoRegM;

  function automatic logic condHolds(cond_t cond, flags_t f);
    logic n, z, c, v;
    n = f[3];
    z = f[2];
    c = f[1];
    v = f[0];
    case (cond)
      condEq:  return z;
      condNe:  return !z;
      condCs:  return c;
      condCc:  return !c;
      condMi:  return n;
      condPl:  return !n;
      condVs:  return v;
      condVc:  return !v;
      condHi:  return c && !z;
      condLs:  return !c || z;
      condGe:  return n == v;
      condLt:  return n != v;
      condGt:  return !z && (n == v);
      condLe:  return z || (n != v);
      condAl:  return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // An all-zero word is a flushed slot
  assign validD = |instrD;
  assign classD = instrClass_t'(instrD[27:26]);

  always_comb begin
    regSrcD    = 2'b00;
    immSrcD    = 2'b00;
    aluSrcD    = 1'b0;
    aluCtrlD   = aluAdd;
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memtoRegD  = 1'b0;
    memReqD    = 1'b0;
    branchD    = 1'b0;
    flagWriteD = 2'b00;
    dpOkD      = 1'b1;
    case (classD)
      dataProc: begin
        aluSrcD   = instrD[25];
        regWriteD = 1'b1;
        case (instrD[24:21])
          opAnd:   aluCtrlD = aluAnd;
          opSub:   aluCtrlD = aluSub;
          opAdd:   aluCtrlD = aluAdd;
          opOrr:   aluCtrlD = aluOrr;
          opMov:   aluCtrlD = aluPassB;
          opCmp: begin
            aluCtrlD  = aluSub;
            regWriteD = 1'b0;
          end
          default: dpOkD = 1'b0;
        endcase
        regWriteD = regWriteD && dpOkD;
        // Logic ops keep C and V
        if (instrD[20] && dpOkD) begin
          flagWriteD = (aluCtrlD == aluAdd || aluCtrlD == aluSub) ? 2'b11 : 2'b10;
        end
      end
      memory: begin
        regSrcD   = {!instrD[20], 1'b0};
        immSrcD   = 2'b01;
        aluSrcD   = 1'b1;
        regWriteD = instrD[20];
        memtoRegD = instrD[20];
        memWriteD = !instrD[20];
        memReqD   = 1'b1;
      end
      branch: begin
        regSrcD = 2'b01;
        immSrcD = 2'b10;
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validE       <= 1'b0;
      aluSrcE      <= 1'b0;
      aluCtrlE     <= aluAdd;
      regWriteE    <= 1'b0;
      memWriteE    <= 1'b0;
      memtoRegRawE <= 1'b0;
      memReqE      <= 1'b0;
      branchE      <= 1'b0;
      flagWriteE   <= 2'b00;
      condE        <= condAl;
    end else begin
      validE       <= validD && !flushE;
      aluSrcE      <= aluSrcD;
      aluCtrlE     <= aluCtrlD;
      regWriteE    <= regWriteD;
      memWriteE    <= memWriteD;
      memtoRegRawE <= memtoRegD;
      memReqE      <= memReqD;
      branchE      <= branchD;
      flagWriteE   <= flagWriteD;
      condE        <= instrD[31:28];
    end
  end

  // Condition check gates every side effect in E
  assign passE        = validE && condHolds(condE, flagReg);
  assign branchTakenE = passE && branchE;
  assign memtoRegE    = validE && memtoRegRawE;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagReg <= '0;
    end else if (passE) begin
      if (flagWriteE[1]) begin
        flagReg[3:2] <= aluFlagsE[3:2];
      end
      if (flagWriteE[0]) begin
        flagReg[1:0] <= aluFlagsE[1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memReqM   <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
    end else begin
      regWriteM <= passE && regWriteE;
      memWriteM <= passE && memWriteE;
      memReqM   <= passE && memReqE;
      memtoRegM <= memtoRegRawE;
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
    end
  end

  // Slot behind a taken branch must not execute
  aBranchSquash: assert property (@(posedge clk) disable iff (!rstN) branchTakenE |=> !validE)
    else $error("instruction behind a taken branch still valid in E");

endmodule

/* datapath.sv */
`timescale 1ns/10ps

module datapath
  import armPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic [1:0] regSrcD,
  input  logic [1:0] immSrcD,
  input  logic       aluSrcE,
  input  logic       branchTakenE,
  input  aluCtrl_t   aluCtrlE,
  input  logic       memtoRegW,
  input  logic       regWriteW,
  output word_t      pcF,
  input  word_t      instrF,
  output word_t      instrD,
  output word_t      aluOutM,
  output word_t      writeDataM,
  input  word_t      readDataM,
  output flags_t     aluFlagsE,
  output logic       match1EM,
  output logic       match1EW,
  output logic       match2EM,
  output logic       match2EW,
  output logic       match12DE,
  input  logic [1:0] forwardAE,
  input  logic [1:0] forwardBE,
  input  logic       stallF,
  input  logic       stallD,
  input  logic       flushD,
  input  logic       flushE
);

  word_t       pcPlus4F, pcNextF, pcPlus8D;
  word_t       rd1D, rd2D, extImmD, immZeroD;
  logic [63:0] rotWideD;
  regIdx_t     ra1D, ra2D, wa3D;
  word_t       regFile [16];

  word_t       rd1E, rd2E, extImmE, srcAE, srcBE, writeDataE, aluResultE, bEffE;
  logic [32:0] sumE;
  logic        subE;
  regIdx_t     ra1E, ra2E, wa3E, wa3M, wa3W;
  word_t       aluOutW, readDataW, resultW;

  // Fetch
  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  // Decode
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= '0;
    end else if (flushD) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  // Fetch is one word ahead of decode, so PC+4 in F is PC+8 in D
  assign pcPlus8D = pcPlus4F;

  assign ra1D = regSrcD[0] ? 4'hF : instrD[19:16];
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];
  assign wa3D = instrD[15:12];

  always_ff @(posedge clk) begin
    if (regWriteW && wa3W != 4'hF) begin
      regFile[wa3W] <= resultW;
    end
  end

  // Write-back result is visible to decode in the same cycle
  assign rd1D = (ra1D == 4'hF) ? pcPlus8D :
                (regWriteW && wa3W == ra1D) ? resultW : regFile[ra1D];
  assign rd2D = (ra2D == 4'hF) ? pcPlus8D :
                (regWriteW && wa3W == ra2D) ? resultW : regFile[ra2D];

  // Rotate right by twice the 4-bit rotate field
  assign immZeroD = {24'b0, instrD[7:0]};
  assign rotWideD = {immZeroD, immZeroD} >> {instrD[11:8], 1'b0};

  always_comb begin
    case (immSrcD)
      2'b00:   extImmD = rotWideD[31:0];
      2'b01:   extImmD = {20'b0, instrD[11:0]};
      default: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
    endcase
  end

  // Execute
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
      ra1E    <= '0;
      ra2E    <= '0;
      wa3E    <= '0;
    end else if (flushE) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
      ra1E    <= '0;
      ra2E    <= '0;
      wa3E    <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
      ra1E    <= ra1D;
      ra2E    <= ra2D;
      wa3E    <= wa3D;
    end
  end

  // Bypass select 2 takes the M result and 1 the W result
  always_comb begin
    case (forwardAE)
      2'b10:   srcAE = aluOutM;
      2'b01:   srcAE = resultW;
      default: srcAE = rd1E;
    endcase
    case (forwardBE)
      2'b10:   writeDataE = aluOutM;
      2'b01:   writeDataE = resultW;
      default: writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? extImmE : writeDataE;

  // Subtract as A + ~B + 1 so carry follows the ARM convention
  assign subE  = (aluCtrlE == aluSub);
  assign bEffE = subE ? ~srcBE : srcBE;
  assign sumE  = {1'b0, srcAE} + {1'b0, bEffE} + {32'b0, subE};

  always_comb begin
    case (aluCtrlE)
      aluAdd,
      aluSub:  aluResultE = sumE[31:0];
      aluAnd:  aluResultE = srcAE & srcBE;
      aluOrr:  aluResultE = srcAE | srcBE;
      default: aluResultE = srcBE;
    endcase
  end

  assign aluFlagsE = {aluResultE[31],
                      aluResultE == '0,
                      sumE[32],
                      ~(srcAE[31] ^ bEffE[31]) & (srcAE[31] ^ sumE[31])};

  // Memory
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluOutM    <= '0;
      writeDataM <= '0;
      wa3M       <= '0;
    end else begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      wa3M       <= wa3E;
    end
  end

  // Write-back
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluOutW   <= '0;
      readDataW <= '0;
      wa3W      <= '0;
    end else begin
      aluOutW   <= aluOutM;
      readDataW <= readDataM;
      wa3W      <= wa3M;
    end
  end

  assign resultW = memtoRegW ? readDataW : aluOutW;

  // Register matches for the hazard unit
  assign match1EM  = (wa3M == ra1E);
  assign match1EW  = (wa3W == ra1E);
  assign match2EM  = (wa3M == ra2E);
  assign match2EW  = (wa3W == ra2E);
  assign match12DE = (wa3E == ra1D) || (wa3E == ra2D);

  aForwardSel: assert property (@(posedge clk) disable iff (!rstN)
    forwardAE != 2'b11 && forwardBE != 2'b11)
    else $error("forward select took reserved value");

endmodule

/* memPkg.sv */
package memPkg;

  // Word address width of the unified memory
  localparam int memAddrW = 10;

  // Number of 32-bit words
  localparam int memDepth = 1024;

  // Image loaded into memory at start
  localparam string progFile = "program.hex";

  // Who drives the memory port this cycle
  typedef enum logic {
    ownFetch,
    ownData
  } busOwner_t;

endpackage

/* armPkg.sv */
package armPkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Register number with R15 as the PC
  typedef logic [3:0] regIdx_t;

  // Condition field of an instruction
  typedef logic [3:0] cond_t;

  // Flags ordered {N, Z, C, V}
  typedef logic [3:0] flags_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluPassB
  } aluCtrl_t;

  // Major class from instruction bits 27:26
  typedef enum logic [1:0] {
    dataProc,
    memory,
    branch,
    other
  } instrClass_t;

  // Data-processing opcodes in bits 24:21
  localparam logic [3:0] opAnd = 4'h0;
  localparam logic [3:0] opSub = 4'h2;
  localparam logic [3:0] opAdd = 4'h4;
  localparam logic [3:0] opCmp = 4'hA;
  localparam logic [3:0] opOrr = 4'hC;
  localparam logic [3:0] opMov = 4'hD;

  // Condition codes
  localparam cond_t condEq = 4'h0;
  localparam cond_t condNe = 4'h1;
  localparam cond_t condCs = 4'h2;
  localparam cond_t condCc = 4'h3;
  localparam cond_t condMi = 4'h4;
  localparam cond_t condPl = 4'h5;
  localparam cond_t condVs = 4'h6;
  localparam cond_t condVc = 4'h7;
  localparam cond_t condHi = 4'h8;
  localparam cond_t condLs = 4'h9;
  localparam cond_t condGe = 4'hA;
  localparam cond_t condLt = 4'hB;
  localparam cond_t condGt = 4'hC;
  localparam cond_t condLe = 4'hD;
  localparam cond_t condAl = 4'hE;

endpackage
